//--- src/conv_pkg.sv
package conv_pkg;

    //////////////////////////////////////////////////////////////////////
    // Frame and kernel geometry
    //////////////////////////////////////////////////////////////////////

    localparam int FRAME_W     = 31;
    localparam int FRAME_H     = 31;
    localparam int KERNEL      = 5;
    localparam int NUM_FILTERS = 2;

    // Raster counter widths
    localparam int COL_W = $clog2(FRAME_W);
    localparam int ROW_W = $clog2(FRAME_H);

    //////////////////////////////////////////////////////////////////////
    // Datapath widths and timing
    //////////////////////////////////////////////////////////////////////

    localparam int PIX_W  = 8;
    localparam int WGT_W  = 16;
    localparam int ACC_W  = 32;
    localparam int FEAT_W = 16;

    // Pixel accept edge to registered feature
    localparam int PIPE_LATENCY = 8;

    // 25 weights then one bias, per filter
    localparam string COEFF_FILE = "src/coeffs.mem";

    typedef logic        [PIX_W-1:0]  pixel_t;
    typedef logic signed [WGT_W-1:0]  weight_t;
    typedef logic signed [ACC_W-1:0]  acc_t;
    typedef logic signed [FEAT_W-1:0] feature_t;

    // Row 0 is the oldest line, column 0 the leftmost pixel
    typedef pixel_t window_t [KERNEL][KERNEL];

endpackage

//--- src/adder_tree.sv
`timescale 1ns/1ps

module adder_tree #(
    parameter int N_IN = 25
) (
    input  logic           i_clk,
    input  logic           i_rst,
    input  logic           i_valid,
    input  conv_pkg::acc_t i_terms [N_IN],
    output conv_pkg::acc_t o_sum,
    output logic           o_valid
);

    import conv_pkg::*;

    // One registered stage per halving of the term count
    localparam int STAGES = $clog2(N_IN);

    // Terms left after a number of halvings
    function automatic int level_size(input int level);
        return (N_IN + (1 << level) - 1) >> level;
    endfunction

    acc_t              stage_in  [STAGES][N_IN];
    acc_t              stage_out [STAGES][N_IN];
    logic [STAGES-1:0] valid_sr;

    // Each stage reads the registers of the one before
    always_comb begin
        stage_in[0] = i_terms;
        for (int s = 1; s < STAGES; s++) begin
            stage_in[s] = stage_out[s-1];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Pairwise add stages
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        for (int s = 0; s < STAGES; s++) begin
            // Slots past the live terms stay zero
            for (int j = 0; j < N_IN; j++) begin
                stage_out[s][j] <= '0;
            end
            for (int j = 0; j < N_IN / 2; j++) begin
                if (j < level_size(s) / 2) begin
                    stage_out[s][j] <= stage_in[s][2*j] + stage_in[s][2*j+1];
                end
            end
            // odd leftover goes through unchanged
            if (level_size(s) % 2 == 1) begin
                stage_out[s][level_size(s)/2] <= stage_in[s][level_size(s)-1];
            end
        end
    end

    // Valid travels alongside the data, one bit per stage
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            valid_sr <= '0;
        end else begin
            valid_sr <= (valid_sr << 1) | STAGES'(i_valid);
        end
    end

    assign o_sum   = stage_out[STAGES-1][0];
    assign o_valid = valid_sr[STAGES-1];

    assert property (@(posedge i_clk) disable iff (i_rst) !$isunknown(o_valid));

endmodule

//--- src/pixel_window.sv
`timescale 1ns/1ps

module pixel_window (
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              i_pixel_valid,
    input  conv_pkg::pixel_t  i_pixel,
    output conv_pkg::window_t o_window,
    output logic              o_window_valid
);

    import conv_pkg::*;

    // Raster position of the next pixel to arrive
    logic [COL_W-1:0] col_cnt;
    logic [ROW_W-1:0] row_cnt;
    logic             last_col;
    logic             last_row;
    logic             in_window;
    logic             cnt_in_range;

    // Previous four lines with the oldest at index 0
    pixel_t line_buf [KERNEL-1][FRAME_W];

    // New right-hand column one cycle ahead of the window
    pixel_t col_data [KERNEL];
    logic   col_load;
    logic   col_hit;

    //////////////////////////////////////////////////////////////////////
    // Raster counters
    //////////////////////////////////////////////////////////////////////

    assign last_col = (col_cnt == COL_W'(FRAME_W - 1));
    assign last_row = (row_cnt == ROW_W'(FRAME_H - 1));

    // Window ends at this pixel and lies fully inside the frame
    assign in_window = (row_cnt >= ROW_W'(KERNEL - 1)) && (col_cnt >= COL_W'(KERNEL - 1));

    assign cnt_in_range = (row_cnt <= ROW_W'(FRAME_H - 1)) && (col_cnt <= COL_W'(FRAME_W - 1));

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            col_cnt <= '0;
            row_cnt <= '0;
        end else if (i_pixel_valid) begin
            if (last_col) begin
                col_cnt <= '0;
                // End of frame wraps straight into the next one
                row_cnt <= last_row ? '0 : row_cnt + 1'b1;
            end else begin
                col_cnt <= col_cnt + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Line buffers and column fetch
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (i_pixel_valid) begin
            // Column above the pixel plus the pixel itself
            for (int k = 0; k < KERNEL - 1; k++) begin
                col_data[k] <= line_buf[k][col_cnt];
            end
            col_data[KERNEL-1] <= i_pixel;
            // Age this column by one line so the oldest entry drops out
            for (int k = 0; k < KERNEL - 2; k++) begin
                line_buf[k][col_cnt] <= line_buf[k+1][col_cnt];
            end
            line_buf[KERNEL-2][col_cnt] <= i_pixel;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            col_load <= 1'b0;
            col_hit  <= 1'b0;
        end else begin
            col_load <= i_pixel_valid;
            col_hit  <= i_pixel_valid && in_window;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Sliding window
    //////////////////////////////////////////////////////////////////////

    // Shift left one column per accepted pixel and hold through gaps
    always_ff @(posedge i_clk) begin
        if (col_load) begin
            for (int r = 0; r < KERNEL; r++) begin
                for (int c = 0; c < KERNEL - 1; c++) begin
                    o_window[r][c] <= o_window[r][c+1];
                end
                o_window[r][KERNEL-1] <= col_data[r];
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_window_valid <= 1'b0;
        end else begin
            o_window_valid <= col_hit;
        end
    end

    // Raster counters stay inside the frame whenever a window is valid
    assert property (@(posedge i_clk) disable iff (i_rst)
        o_window_valid |-> cnt_in_range);

endmodule

//--- src/filter_mac.sv
`timescale 1ns/1ps

module filter_mac #(
    parameter int FILTER_IDX = 0
) (
    input  logic               i_clk,
    input  logic               i_rst,
    input  conv_pkg::window_t  i_window,
    input  logic               i_window_valid,
    output conv_pkg::feature_t o_feature,
    output logic               o_feature_valid
);

    import conv_pkg::*;

    // First entry of this filter, 25 weights then its bias
    localparam int BASE = FILTER_IDX * (KERNEL * KERNEL + 1);

    // Coefficients for all filters, one line each in the file
    weight_t coeff_rom [NUM_FILTERS * (KERNEL * KERNEL + 1)];

    acc_t products [KERNEL * KERNEL];
    logic prod_valid;
    acc_t tree_sum;
    logic tree_valid;
    acc_t biased;

    initial begin
        $readmemh(COEFF_FILE, coeff_rom);
    end

    //////////////////////////////////////////////////////////////////////
    // Multipliers
    //////////////////////////////////////////////////////////////////////

    // Signed weight times zero-extended pixel, all 25 in parallel
    always_ff @(posedge i_clk) begin
        for (int r = 0; r < KERNEL; r++) begin
            for (int c = 0; c < KERNEL; c++) begin
                products[r*KERNEL+c] <= acc_t'(coeff_rom[BASE + r*KERNEL + c])
                                      * acc_t'($signed({1'b0, i_window[r][c]}));
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            prod_valid <= 1'b0;
        end else begin
            prod_valid <= i_window_valid;
        end
    end

    // Five stages for 25 terms
    adder_tree #(
        .N_IN(KERNEL * KERNEL)
    ) tree_inst (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_valid (prod_valid),
        .i_terms (products),
        .o_sum   (tree_sum),
        .o_valid (tree_valid)
    );

    //////////////////////////////////////////////////////////////////////
    // Bias and output register
    //////////////////////////////////////////////////////////////////////

    assign biased = tree_sum + acc_t'(coeff_rom[BASE + KERNEL * KERNEL]);

    // Low bits only, wraps like the reference model
    always_ff @(posedge i_clk) begin
        o_feature <= biased[FEAT_W-1:0];
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_feature_valid <= 1'b0;
        end else begin
            o_feature_valid <= tree_valid;
        end
    end

    // Window valid to feature valid is one cycle short of the full latency
    assert property (@(posedge i_clk) disable iff (i_rst)
        i_window_valid |-> ##(PIPE_LATENCY - 1) o_feature_valid);
    assert property (@(posedge i_clk) disable iff (i_rst)
        o_feature_valid |-> $past(i_window_valid, PIPE_LATENCY - 1));

endmodule

//--- src/conv_top.sv
`timescale 1ns/1ps

module conv_top (
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic               i_pixel_valid,
    input  conv_pkg::pixel_t   i_pixel,
    output logic               o_feature_valid,
    output conv_pkg::feature_t o_features [conv_pkg::NUM_FILTERS]
);

    import conv_pkg::*;

    // Shared window feeding every filter
    window_t window;
    logic    window_valid;
    logic    feature_valid [NUM_FILTERS];

    pixel_window window_inst (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_pixel_valid  (i_pixel_valid),
        .i_pixel        (i_pixel),
        .o_window       (window),
        .o_window_valid (window_valid)
    );

    //////////////////////////////////////////////////////////////////////
    // Filter bank
    //////////////////////////////////////////////////////////////////////

    for (genvar f = 0; f < NUM_FILTERS; f++) begin : g_filter
        filter_mac #(
            .FILTER_IDX(f)
        ) filter_inst (
            .i_clk           (i_clk),
            .i_rst           (i_rst),
            .i_window        (window),
            .i_window_valid  (window_valid),
            .o_feature       (o_features[f]),
            .o_feature_valid (feature_valid[f])
        );
    end

    // All filters run in lockstep, filter 0 speaks for the bank
    assign o_feature_valid = feature_valid[0];

endmodule

//--- sim/conv_tb.sv
`timescale 1ns/1ps

module conv_tb;

    import conv_pkg::*;

    localparam int NUM_COEFFS  = NUM_FILTERS * (KERNEL * KERNEL + 1);
    localparam int FRAME_PIX   = FRAME_W * FRAME_H;
    localparam int FRAME_OUTS  = (FRAME_W - KERNEL + 1) * (FRAME_H - KERNEL + 1);
    localparam int DRAIN_LIMIT = 64;

    // One expected result, due cycle counted in clock edges
    typedef struct packed {
        int                                 due;
        logic                               last;
        logic [NUM_FILTERS-1:0][FEAT_W-1:0] val;
    } expect_t;

    logic     i_clk;
    logic     i_rst;
    logic     i_pixel_valid;
    pixel_t   i_pixel;
    logic     o_feature_valid;
    feature_t o_features [NUM_FILTERS];

    weight_t  coeffs [NUM_COEFFS];
    pixel_t   frame_pix [FRAME_H][FRAME_W];
    expect_t  exp_q [$];

    // Model raster position and bookkeeping
    int   m_row = 0;
    int   m_col = 0;
    int   cyc = 0;
    logic rst_prev = 1'b0;
    int   pulse_cnt = 0;
    int   frames_done = 0;
    int   value_errs = 0;
    int   timing_errs = 0;
    int   other_errs = 0;
    int   flow_errs = 0;

    conv_top conv_top_inst (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_pixel_valid   (i_pixel_valid),
        .i_pixel         (i_pixel),
        .o_feature_valid (o_feature_valid),
        .o_features      (o_features)
    );

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    ///////////////////////////////////////////////////////////////////////
    // Reference model
    ///////////////////////////////////////////////////////////////////////

    // Bias plus weighted 5x5 block ending at (r, c), wrapped to 16 bits
    function automatic feature_t model_feature(input int f, input int r, input int c);
        int acc;
        int base;
        base = f * (KERNEL * KERNEL + 1);
        acc = int'(coeffs[base + KERNEL * KERNEL]);
        for (int i = 0; i < KERNEL; i++) begin
            for (int j = 0; j < KERNEL; j++) begin
                acc += int'(coeffs[base + i * KERNEL + j])
                     * int'(frame_pix[r - KERNEL + 1 + i][c - KERNEL + 1 + j]);
            end
        end
        return feature_t'(acc[FEAT_W-1:0]);
    endfunction

    // Outputs seen here were registered on edge number cyc
    task automatic check_outputs();
        expect_t e;
        if (rst_prev && o_feature_valid !== 1'b0) begin
            other_errs++;
            $display("Error at %0t: o_feature_valid high while in reset", $time);
        end else if ($isunknown(o_feature_valid)) begin
            other_errs++;
            $display("Error at %0t: o_feature_valid is unknown", $time);
        end else if (o_feature_valid) begin
            pulse_cnt++;
            if (exp_q.size() == 0) begin
                other_errs++;
                $display("Error at %0t: result pulse with no result pending", $time);
            end else begin
                e = exp_q.pop_front();
                if (e.due != cyc) begin
                    timing_errs++;
                    $display("[FAIL] %0t o_feature_valid cycle: got %0d expected %0d",
                             $time, cyc, e.due);
                end
                for (int f = 0; f < NUM_FILTERS; f++) begin
                    if (o_features[f] !== e.val[f]) begin
                        value_errs++;
                        $display("[FAIL] %0t o_features[%0d]: got %0d expected %0d",
                                 $time, f, o_features[f], $signed(e.val[f]));
                    end
                end
                // Last window of a frame closes the pulse count
                if (e.last) begin
                    if (pulse_cnt != FRAME_OUTS) begin
                        other_errs++;
                        $display("[FAIL] %0t o_feature_valid pulses per frame: got %0d expected %0d",
                                 $time, pulse_cnt, FRAME_OUTS);
                    end
                    frames_done++;
                    pulse_cnt = 0;
                end
            end
        end else if (exp_q.size() > 0 && exp_q[0].due <= cyc) begin
            timing_errs++;
            $display("Error at %0t: result due at cycle %0d never pulsed", $time, exp_q[0].due);
            void'(exp_q.pop_front());
        end
    endtask

    always @(posedge i_clk) begin : monitor
        expect_t e;
        if (cyc > 0) begin
            check_outputs();
        end
        if (i_rst) begin
            // Raster restarts, nothing in flight survives
            m_row = 0;
            m_col = 0;
            pulse_cnt = 0;
            exp_q.delete();
        end else if (i_pixel_valid) begin
            frame_pix[m_row][m_col] = i_pixel;
            if (m_row >= KERNEL - 1 && m_col >= KERNEL - 1) begin
                e.due = cyc + 1 + PIPE_LATENCY;
                e.last = (m_row == FRAME_H - 1) && (m_col == FRAME_W - 1);
                for (int f = 0; f < NUM_FILTERS; f++) begin
                    e.val[f] = model_feature(f, m_row, m_col);
                end
                exp_q.push_back(e);
            end
            if (m_col == FRAME_W - 1) begin
                m_col = 0;
                m_row = (m_row == FRAME_H - 1) ? 0 : m_row + 1;
            end else begin
                m_col++;
            end
        end
        rst_prev = i_rst;
        cyc++;
    end

    ///////////////////////////////////////////////////////////////////////
    // Stimulus
    ///////////////////////////////////////////////////////////////////////

    // Random pixels with roughly 30 percent idle cycles
    task automatic send_pixels(input int count);
        int sent;
        int spins;
        sent = 0;
        spins = 0;
        while (sent < count && spins < count * 20) begin
            @(posedge i_clk);
            spins++;
            i_pixel <= pixel_t'($urandom);
            if ($urandom % 10 < 7) begin
                i_pixel_valid <= 1'b1;
                sent++;
            end else begin
                i_pixel_valid <= 1'b0;
            end
        end
        if (sent < count) begin
            flow_errs++;
            $display("Error: only %0d of %0d pixels could be sent", sent, count);
        end
    endtask

    task automatic apply_reset();
        @(posedge i_clk);
        i_rst <= 1'b1;
        i_pixel_valid <= 1'b0;
        repeat (2) @(posedge i_clk);
        i_rst <= 1'b0;
    endtask

    initial begin : stimulus
        int waited;
        void'($urandom(32'h9029_991d));
        $readmemh(COEFF_FILE, coeffs);
        i_rst = 1'b1;
        i_pixel_valid = 1'b0;
        i_pixel = '0;
        repeat (2) @(posedge i_clk);
        i_rst <= 1'b0;

        // Two frames back to back, then a frame cut short by reset
        send_pixels(FRAME_PIX);
        send_pixels(FRAME_PIX);
        send_pixels(12 * FRAME_W + 9);
        apply_reset();
        send_pixels(FRAME_PIX);
        @(posedge i_clk);
        i_pixel_valid <= 1'b0;

        waited = 0;
        while (exp_q.size() > 0 && waited < DRAIN_LIMIT) begin
            @(posedge i_clk);
            waited++;
        end
        if (exp_q.size() > 0) begin
            flow_errs++;
            $display("Timeout: %0d results never arrived", exp_q.size());
        end
        // Quiet tail catches stray pulses
        repeat (16) @(posedge i_clk);
        if (frames_done != 3) begin
            flow_errs++;
            $display("Error: %0d complete frames seen instead of 3", frames_done);
        end

        $display("Errors: value %0d, timing %0d, other %0d",
                 value_errs, timing_errs, other_errs + flow_errs);
        if (value_errs + timing_errs + other_errs + flow_errs == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
src/conv_pkg.sv
src/adder_tree.sv
src/pixel_window.sv
src/filter_mac.sv
src/conv_top.sv
sim/conv_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal -j 0
TOP      = conv_tb
FILELIST = vlog.f
BUILD    = obj_dir
PASS_MSG = Simulation completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build $(TOP) with $(SIM) and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)

//--- src/coeffs.mem
// One 16-bit hex value per line: filter 0 weights row by row, its bias, then filter 1
0001
0004
0006
0004
0001
0004
0010
0018
0010
0004
0006
0018
0024
0018
0006
0004
0010
0018
0010
0004
0001
0004
0006
0004
0001
FF80
0123
FEDC
0040
FF00
07FF
F800
0011
FFEE
0200
FC18
00FA
FF06
0001
FFFF
1234
EDCC
0080
FF80
0333
FCCD
0055
FFAB
00C8
FF38
0010
1F40
